// ==== sam_pkg.sv ====
package sam_pkg;

    // ----------------------------------------------------------------------
    // Bus widths
    // ----------------------------------------------------------------------
    localparam int CPU_ADDR_W = 16;
    localparam int DATA_W     = 8;
    localparam int RAM_ADDR_W = 19;
    localparam int ROM_ADDR_W = 15;
    localparam int PAGE_W     = 5;
    // Offset inside one 16 KB page or ROM half
    localparam int OFFSET_W   = 14;
    // Two 16 KB halves
    localparam int ROM_DEPTH  = 1 << ROM_ADDR_W;

    typedef logic [CPU_ADDR_W-1:0] cpu_addr_t;
    typedef logic [DATA_W-1:0]     byte_t;
    typedef logic [RAM_ADDR_W-1:0] ram_addr_t;
    // Top bit picks ROM1
    typedef logic [ROM_ADDR_W-1:0] rom_addr_t;
    // 32 pages of 16 KB fill the 512 KB SRAM
    typedef logic [PAGE_W-1:0]     page_t;

    // ----------------------------------------------------------------------
    // ASIC port numbers (low address byte)
    // ----------------------------------------------------------------------
    localparam byte_t PORT_LMPR   = 8'hFA;
    localparam byte_t PORT_HMPR   = 8'hFB;
    // Border/mic/beep on write, keyboard/ear on read
    localparam byte_t PORT_BORDER = 8'hFE;

    // ----------------------------------------------------------------------
    // Register bit positions
    // ----------------------------------------------------------------------
    // RAM instead of ROM0 in section A
    localparam int LMPR_RAM0_BIT   = 5;
    // ROM1 in section D
    localparam int LMPR_ROM1_BIT   = 6;
    localparam int BORDER_MIC_BIT  = 3;
    localparam int BORDER_BEEP_BIT = 4;
    localparam int KEY_EAR_BIT     = 6;

    // Floating bus value of an unmapped port
    localparam byte_t IO_IDLE_DATA = 8'hFF;

endpackage

// ==== sam_rom.sv ====
`timescale 1ns/1ps

module sam_rom (
    input  logic                clk24,
    input  sam_pkg::rom_addr_t  rom_addr,
    output sam_pkg::byte_t      rom_data
);

    // ROM0 in the lower half, ROM1 in the upper
    sam_pkg::byte_t mem [0:sam_pkg::ROM_DEPTH-1];

    initial begin
        $readmemh("sam_rom.hex", mem);
    end

    // One cycle read latency
    always_ff @(posedge clk24) begin
        rom_data <= mem[rom_addr];
    end

endmodule

// ==== sam_mem_map.sv ====
`timescale 1ns/1ps

module sam_mem_map (
    input  logic                clk24,
    input  logic                rst_n,
    // Z80 strobes
    input  logic                mreq_n,
    input  logic                iorq_n,
    input  logic                rd_n,
    input  logic                wr_n,
    input  sam_pkg::cpu_addr_t  cpu_addr,
    // Paging registers from the I/O block
    input  sam_pkg::byte_t      lmpr,
    input  sam_pkg::byte_t      hmpr,
    // Access starts, one cycle each
    output logic                rom_start,
    output logic                ram_start,
    output logic                io_start,
    output logic                access_write,
    output sam_pkg::rom_addr_t  rom_addr,
    output sam_pkg::ram_addr_t  ram_addr,
    output sam_pkg::byte_t      io_port
);

    logic               acc_now;
    logic               acc_q;
    logic               start;
    logic               map_rom;
    logic               rom_hi;
    sam_pkg::page_t     page;
    sam_pkg::page_t     lmpr_page;
    sam_pkg::page_t     hmpr_page;

    // ------------------------------------------------------------------
    // Access detection
    // ------------------------------------------------------------------
    // Refresh cycles have mreq_n low but no rd_n/wr_n, so they never start
    assign acc_now = (~mreq_n | ~iorq_n) & (~rd_n | ~wr_n);

    always_ff @(posedge clk24) begin
        if (!rst_n) begin
            acc_q <= 1'b0;
        end else begin
            acc_q <= acc_now;
        end
    end

    // Rising edge of the combined strobes
    assign start     = acc_now & ~acc_q;
    assign rom_start = start & ~mreq_n & map_rom;
    assign ram_start = start & ~mreq_n & ~map_rom;
    assign io_start  = start & ~iorq_n;

    assign access_write = ~wr_n;
    assign io_port      = cpu_addr[7:0];

    // ------------------------------------------------------------------
    // Section mapping
    // ------------------------------------------------------------------
    assign lmpr_page = lmpr[sam_pkg::PAGE_W-1:0];
    assign hmpr_page = hmpr[sam_pkg::PAGE_W-1:0];

    always_comb begin
        map_rom = 1'b0;
        rom_hi  = 1'b0;
        page    = lmpr_page;
        case (cpu_addr[15:14])
            // Section A, ROM0 unless switched to RAM
            2'd0: map_rom = ~lmpr[sam_pkg::LMPR_RAM0_BIT];
            // Section B, next page wraps 31 to 0
            2'd1: page = lmpr_page + sam_pkg::page_t'(1);
            2'd2: page = hmpr_page;
            // Section D, ROM1 when enabled
            default: begin
                map_rom = lmpr[sam_pkg::LMPR_ROM1_BIT];
                rom_hi  = 1'b1;
                page    = hmpr_page + sam_pkg::page_t'(1);
            end
        endcase
    end

    assign ram_addr = {page, cpu_addr[sam_pkg::OFFSET_W-1:0]};
    assign rom_addr = {rom_hi, cpu_addr[sam_pkg::OFFSET_W-1:0]};

    // Bus protocol from the CPU side
    a_one_space: assert property (@(posedge clk24) disable iff (!rst_n)
        !(!mreq_n && !iorq_n));
    a_one_dir: assert property (@(posedge clk24) disable iff (!rst_n)
        !(!rd_n && !wr_n));

endmodule

// ==== sam_io_ports.sv ====
`timescale 1ns/1ps

module sam_io_ports (
    input  logic            clk24,
    input  logic            rst_n,
    // Decoded I/O access
    input  logic            io_start,
    input  logic            access_write,
    input  sam_pkg::byte_t  io_port,
    input  sam_pkg::byte_t  cpu_dout,
    // Keyboard columns and tape input
    input  logic [4:0]      kb_cols,
    input  logic            ear,
    // Register outputs
    output sam_pkg::byte_t  lmpr,
    output sam_pkg::byte_t  hmpr,
    output sam_pkg::byte_t  io_rdata,
    output logic [2:0]      border,
    output logic            mic,
    output logic            beep
);

    logic            io_wr;
    logic            io_rd;
    sam_pkg::byte_t  key_byte;
    sam_pkg::byte_t  rd_mux;

    assign io_wr = io_start & access_write;
    assign io_rd = io_start & ~access_write;

    // ------------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------------
    // Zero after reset, so ROM0 is in and ROM1 out
    always_ff @(posedge clk24) begin
        if (!rst_n) begin
            lmpr   <= '0;
            hmpr   <= '0;
            border <= '0;
            mic    <= 1'b0;
            beep   <= 1'b0;
        end else if (io_wr) begin
            case (io_port)
                sam_pkg::PORT_LMPR: lmpr <= cpu_dout;
                sam_pkg::PORT_HMPR: hmpr <= cpu_dout;
                sam_pkg::PORT_BORDER: begin
                    border <= cpu_dout[2:0];
                    mic    <= cpu_dout[sam_pkg::BORDER_MIC_BIT];
                    beep   <= cpu_dout[sam_pkg::BORDER_BEEP_BIT];
                end
                default: ;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // Read side
    // ------------------------------------------------------------------
    // Keyboard port layout: 1, ear, 1, five columns
    always_comb begin
        key_byte = 8'hFF;
        key_byte[sam_pkg::KEY_EAR_BIT] = ear;
        key_byte[4:0] = kb_cols;
    end

    always_comb begin
        case (io_port)
            sam_pkg::PORT_LMPR:   rd_mux = lmpr;
            sam_pkg::PORT_HMPR:   rd_mux = hmpr;
            sam_pkg::PORT_BORDER: rd_mux = key_byte;
            default:              rd_mux = sam_pkg::IO_IDLE_DATA;
        endcase
    end

    // Valid from the second strobe cycle on
    always_ff @(posedge clk24) begin
        if (io_rd) begin
            io_rdata <= rd_mux;
        end
    end

endmodule

// ==== sam_memory_access.sv ====
`timescale 1ns/1ps

module sam_memory_access (
    input  logic                clk24,
    input  logic                rst_n,
    // Access starts from the decoder
    input  logic                rom_start,
    input  logic                ram_start,
    input  logic                io_start,
    input  logic                access_write,
    input  sam_pkg::rom_addr_t  rom_addr,
    input  sam_pkg::ram_addr_t  ram_addr,
    input  sam_pkg::byte_t      cpu_dout,
    input  sam_pkg::byte_t      io_rdata,
    // Video fetch port
    input  logic                vid_req,
    input  sam_pkg::ram_addr_t  vid_addr,
    // CPU side
    output logic                wait_n,
    output sam_pkg::byte_t      data_to_cpu,
    output logic                vid_ack,
    output sam_pkg::byte_t      vid_data,
    // External SRAM
    output sam_pkg::ram_addr_t  sram_addr,
    output logic                sram_we_n,
    inout  wire sam_pkg::byte_t sram_data
);

    typedef enum logic [1:0] {SRC_NONE, SRC_ROM, SRC_RAM, SRC_IO} src_e;

    logic            slot;
    logic            vid_cycle;
    logic            ram_pend;
    logic            ram_req;
    logic            grant;
    logic            start_any;
    logic            busy;
    logic            done;
    src_e            src_q;
    sam_pkg::byte_t  rom_data;
    sam_pkg::byte_t  ram_q;
    sam_pkg::byte_t  data_q;
    sam_pkg::byte_t  done_data;

    sam_rom u_rom (
        .clk24    (clk24),
        .rom_addr (rom_addr),
        .rom_data (rom_data)
    );

    // ------------------------------------------------------------------
    // SRAM arbitration
    // ------------------------------------------------------------------
    // Video owns every requested slot-0 cycle
    assign vid_cycle = ~slot & vid_req;
    assign ram_req   = ram_start | ram_pend;
    assign grant     = ram_req & ~vid_cycle;
    assign start_any = rom_start | ram_start | io_start;

    assign sram_addr = vid_cycle ? vid_addr : ram_addr;
    assign sram_we_n = ~(grant & access_write);
    assign sram_data = (grant & access_write) ? cpu_dout : 'z;

    always_ff @(posedge clk24) begin
        if (!rst_n) begin
            slot     <= 1'b0;
            ram_pend <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
            vid_ack  <= 1'b0;
            src_q    <= SRC_NONE;
        end else begin
            slot     <= ~slot;
            vid_ack  <= vid_cycle;
            // Lost one cycle to video, next slot is free
            ram_pend <= ram_req & vid_cycle;
            // ROM and I/O finish one cycle after start, RAM after grant
            done     <= rom_start | io_start | grant;
            if (start_any) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
            if (rom_start) begin
                src_q <= SRC_ROM;
            end else if (ram_start) begin
                src_q <= SRC_RAM;
            end else if (io_start) begin
                src_q <= SRC_IO;
            end
        end
    end

    // ------------------------------------------------------------------
    // Data capture and return
    // ------------------------------------------------------------------
    always_ff @(posedge clk24) begin
        if (vid_cycle) begin
            vid_data <= sram_data;
        end
        if (grant && !access_write) begin
            ram_q <= sram_data;
        end
        // Last returned byte, held between accesses
        data_q <= data_to_cpu;
    end

    always_comb begin
        case (src_q)
            SRC_ROM: done_data = rom_data;
            SRC_RAM: done_data = ram_q;
            SRC_IO:  done_data = io_rdata;
            default: done_data = data_q;
        endcase
    end

    assign data_to_cpu = done ? done_data : data_q;
    // Low from the first strobe cycle until done
    assign wait_n = ~((start_any | busy) & ~done);

    a_no_overlap: assert property (@(posedge clk24) disable iff (!rst_n)
        start_any |-> !busy);
    // Write strobe only inside a RAM access that is still running
    a_write_grant: assert property (@(posedge clk24) disable iff (!rst_n)
        !sram_we_n |-> (ram_start || (busy && !done && src_q == SRC_RAM)));

endmodule

// ==== sam_bus_top.sv ====
`timescale 1ns/1ps

module sam_bus_top (
    input  logic                clk24,
    input  logic                rst_n,
    // Z80 bus
    input  logic                mreq_n,
    input  logic                iorq_n,
    input  logic                rd_n,
    input  logic                wr_n,
    input  sam_pkg::cpu_addr_t  cpu_addr,
    input  sam_pkg::byte_t      cpu_dout,
    output logic                wait_n,
    output sam_pkg::byte_t      data_to_cpu,
    // Keyboard, tape and audio
    input  logic [4:0]          kb_cols,
    input  logic                ear,
    output sam_pkg::byte_t      kb_rows,
    output logic [2:0]          border,
    output logic                mic,
    output logic                beep,
    // Video fetch port
    input  logic                vid_req,
    input  sam_pkg::ram_addr_t  vid_addr,
    output logic                vid_ack,
    output sam_pkg::byte_t      vid_data,
    // External SRAM
    output sam_pkg::ram_addr_t  sram_addr,
    output logic                sram_we_n,
    inout  wire sam_pkg::byte_t sram_data
);

    logic                rom_start;
    logic                ram_start;
    logic                io_start;
    logic                access_write;
    sam_pkg::rom_addr_t  rom_addr;
    sam_pkg::ram_addr_t  ram_addr;
    sam_pkg::byte_t      io_port;
    sam_pkg::byte_t      io_rdata;
    sam_pkg::byte_t      lmpr;
    sam_pkg::byte_t      hmpr;

    // Keyboard rows scanned by the upper address byte
    assign kb_rows = cpu_addr[15:8];

    // ------------------------------------------------------------------
    // Decode, execute, result
    // ------------------------------------------------------------------
    sam_mem_map u_mem_map (
        .clk24        (clk24),
        .rst_n        (rst_n),
        .mreq_n       (mreq_n),
        .iorq_n       (iorq_n),
        .rd_n         (rd_n),
        .wr_n         (wr_n),
        .cpu_addr     (cpu_addr),
        .lmpr         (lmpr),
        .hmpr         (hmpr),
        .rom_start    (rom_start),
        .ram_start    (ram_start),
        .io_start     (io_start),
        .access_write (access_write),
        .rom_addr     (rom_addr),
        .ram_addr     (ram_addr),
        .io_port      (io_port)
    );

    sam_io_ports u_io_ports (
        .clk24        (clk24),
        .rst_n        (rst_n),
        .io_start     (io_start),
        .access_write (access_write),
        .io_port      (io_port),
        .cpu_dout     (cpu_dout),
        .kb_cols      (kb_cols),
        .ear          (ear),
        .lmpr         (lmpr),
        .hmpr         (hmpr),
        .io_rdata     (io_rdata),
        .border       (border),
        .mic          (mic),
        .beep         (beep)
    );

    sam_memory_access u_memory_access (
        .clk24        (clk24),
        .rst_n        (rst_n),
        .rom_start    (rom_start),
        .ram_start    (ram_start),
        .io_start     (io_start),
        .access_write (access_write),
        .rom_addr     (rom_addr),
        .ram_addr     (ram_addr),
        .cpu_dout     (cpu_dout),
        .io_rdata     (io_rdata),
        .vid_req      (vid_req),
        .vid_addr     (vid_addr),
        .wait_n       (wait_n),
        .data_to_cpu  (data_to_cpu),
        .vid_ack      (vid_ack),
        .vid_data     (vid_data),
        .sram_addr    (sram_addr),
        .sram_we_n    (sram_we_n),
        .sram_data    (sram_data)
    );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real HALF_PERIOD = 20.0,
    parameter int  RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    // 40 ns period clock
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Reset held low for a fixed number of rising edges
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// ==== sram_model.sv ====
`timescale 1ns/1ps

module sram_model (
    input  sam_pkg::ram_addr_t  sram_addr,
    input  logic                sram_we_n,
    inout  wire sam_pkg::byte_t sram_data
);

    sam_pkg::byte_t mem [0:(1 << sam_pkg::RAM_ADDR_W)-1];

    // Fill pattern, built from every address bit
    initial begin
        for (int a = 0; a < (1 << sam_pkg::RAM_ADDR_W); a++) begin
            mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'(a >> 16);
        end
    end

    // Output enabled whenever no write is in progress
    assign sram_data = sram_we_n ? mem[sram_addr] : 'z;

    // Level sensitive write
    always @(sram_we_n or sram_addr or sram_data) begin
        if (!sram_we_n) begin
            mem[sram_addr] = sram_data;
        end
    end

endmodule

// ==== tb_sam_bus.sv ====
`timescale 1ns/1ps

module tb_sam_bus;

    localparam int MAX_ENTRIES  = 64;
    localparam int RESET_CYCLES = 10;

    // Entry kinds and check modes
    localparam int K_MEM_RD = 0;
    localparam int K_MEM_WR = 1;
    localparam int K_IO_RD  = 2;
    localparam int K_IO_WR  = 3;
    localparam int CHK_NONE  = 0;
    localparam int CHK_LIT   = 1;
    localparam int CHK_MODEL = 2;

    logic                clk24;
    logic                rst_n;
    logic                mreq_n;
    logic                iorq_n;
    logic                rd_n;
    logic                wr_n;
    sam_pkg::cpu_addr_t  cpu_addr;
    sam_pkg::byte_t      cpu_dout;
    logic                wait_n;
    sam_pkg::byte_t      data_to_cpu;
    logic [4:0]          kb_cols;
    logic                ear;
    sam_pkg::byte_t      kb_rows;
    logic [2:0]          border;
    logic                mic;
    logic                beep;
    logic                vid_req;
    sam_pkg::ram_addr_t  vid_addr;
    logic                vid_ack;
    sam_pkg::byte_t      vid_data;
    sam_pkg::ram_addr_t  sram_addr;
    logic                sram_we_n;
    wire sam_pkg::byte_t sram_data;

    // Stimulus table
    int                  tbl_kind [MAX_ENTRIES];
    sam_pkg::cpu_addr_t  tbl_addr [MAX_ENTRIES];
    sam_pkg::byte_t      tbl_wdata [MAX_ENTRIES];
    sam_pkg::byte_t      tbl_exp [MAX_ENTRIES];
    int                  tbl_chk [MAX_ENTRIES];
    int                  n_entries;

    // Reference model state
    sam_pkg::byte_t      ref_mem [int];
    sam_pkg::byte_t      ref_lmpr;
    sam_pkg::byte_t      ref_hmpr;

    int                  seed;
    int                  err_count;
    int                  check_count;
    int                  cycle_count;
    int                  cycle_limit;
    sam_pkg::ram_addr_t  prev_vid_addr;
    logic                prev_vid_req;
    logic                prev2_vid_req;
    logic                prev_vid_ack;

    tb_clock_gen #(.RESET_CYCLES(RESET_CYCLES)) u_clk (
        .clk   (clk24),
        .rst_n (rst_n)
    );

    sram_model u_sram (
        .sram_addr (sram_addr),
        .sram_we_n (sram_we_n),
        .sram_data (sram_data)
    );

    sam_bus_top uut (
        .clk24 (clk24), .rst_n (rst_n),
        .mreq_n (mreq_n), .iorq_n (iorq_n), .rd_n (rd_n), .wr_n (wr_n),
        .cpu_addr (cpu_addr), .cpu_dout (cpu_dout),
        .wait_n (wait_n), .data_to_cpu (data_to_cpu),
        .kb_cols (kb_cols), .ear (ear), .kb_rows (kb_rows),
        .border (border), .mic (mic), .beep (beep),
        .vid_req (vid_req), .vid_addr (vid_addr),
        .vid_ack (vid_ack), .vid_data (vid_data),
        .sram_addr (sram_addr), .sram_we_n (sram_we_n), .sram_data (sram_data)
    );

    // ----------------------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------------------
    function automatic sam_pkg::byte_t fill_byte(int a);
        return 8'(a) ^ 8'(a >> 8) ^ 8'(a >> 16);
    endfunction

    function automatic sam_pkg::byte_t ref_read(int a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return fill_byte(a);
    endfunction

    // Returns 1 for ROM, and the RAM byte index through ram_idx
    function automatic bit map_is_rom(sam_pkg::cpu_addr_t a, output int ram_idx);
        int sect;
        int page;
        sect = a >> 14;
        page = 0;
        map_is_rom = 0;
        case (sect)
            0: begin
                map_is_rom = !ref_lmpr[5];
                page = ref_lmpr & 31;
            end
            1: page = ((ref_lmpr & 31) + 1) % 32;
            2: page = ref_hmpr & 31;
            default: begin
                map_is_rom = ref_lmpr[6];
                page = ((ref_hmpr & 31) + 1) % 32;
            end
        endcase
        ram_idx = page * 16384 + (a % 16384);
    endfunction

    task automatic add_entry(int kind, sam_pkg::cpu_addr_t a, sam_pkg::byte_t wd,
                             sam_pkg::byte_t ex, int chk);
        tbl_kind[n_entries]  = kind;
        tbl_addr[n_entries]  = a;
        tbl_wdata[n_entries] = wd;
        tbl_exp[n_entries]   = ex;
        tbl_chk[n_entries]   = chk;
        n_entries++;
    endtask

    task automatic check_byte(string name, sam_pkg::byte_t got, sam_pkg::byte_t ex);
        check_count++;
        assert (got === ex) else begin
            err_count++;
            $display("[ERROR] %s got 0x%02h expected 0x%02h", name, got, ex);
        end
    endtask

    // ----------------------------------------------------------------------
    // Table contents
    // ----------------------------------------------------------------------
    task automatic build_table();
        n_entries = 0;
        // ROM0 start bytes
        add_entry(K_MEM_RD, 16'h0000, 8'h00, 8'hF3, CHK_LIT);
        add_entry(K_MEM_RD, 16'h0001, 8'h00, 8'hAF, CHK_LIT);
        add_entry(K_MEM_RD, 16'h0002, 8'h00, 8'h11, CHK_LIT);
        add_entry(K_MEM_RD, 16'h0003, 8'h00, 8'hFF, CHK_LIT);
        add_entry(K_MEM_RD, 16'h0004, 8'h00, 8'hFF, CHK_LIT);
        add_entry(K_MEM_RD, 16'h0005, 8'h00, 8'hC3, CHK_LIT);
        add_entry(K_MEM_RD, 16'h0006, 8'h00, 8'hCB, CHK_LIT);
        add_entry(K_MEM_RD, 16'h0007, 8'h00, 8'h11, CHK_LIT);
        // ROM1 in section D
        add_entry(K_IO_WR, 16'h00FA, 8'h40, 8'h00, CHK_NONE);
        add_entry(K_IO_RD, 16'h00FA, 8'h00, 8'h40, CHK_LIT);
        add_entry(K_MEM_RD, 16'hC000, 8'h00, 8'h2A, CHK_LIT);
        add_entry(K_MEM_RD, 16'hC001, 8'h00, 8'h5D, CHK_LIT);
        add_entry(K_MEM_RD, 16'hC007, 8'h00, 8'h43, CHK_LIT);
        // ROM1 out, section D back to RAM
        add_entry(K_IO_WR, 16'h00FA, 8'h00, 8'h00, CHK_NONE);
        add_entry(K_IO_WR, 16'h00FB, 8'h05, 8'h00, CHK_NONE);
        add_entry(K_IO_RD, 16'h00FB, 8'h00, 8'h05, CHK_LIT);
        add_entry(K_MEM_RD, 16'hC000, 8'h00, 8'h00, CHK_MODEL);
        add_entry(K_MEM_WR, 16'hC000, 8'h00, 8'h00, CHK_NONE);
        add_entry(K_MEM_RD, 16'hC000, 8'h00, 8'h00, CHK_MODEL);
        add_entry(K_MEM_WR, 16'h8010, 8'h00, 8'h00, CHK_NONE);
        add_entry(K_MEM_RD, 16'h8010, 8'h00, 8'h00, CHK_MODEL);
        // RAM in section A, page 31, section B wraps to 0
        add_entry(K_IO_WR, 16'h00FA, 8'h3F, 8'h00, CHK_NONE);
        add_entry(K_IO_RD, 16'h00FA, 8'h00, 8'h3F, CHK_LIT);
        add_entry(K_MEM_WR, 16'h0123, 8'h00, 8'h00, CHK_NONE);
        add_entry(K_MEM_RD, 16'h0123, 8'h00, 8'h00, CHK_MODEL);
        add_entry(K_MEM_WR, 16'h4567, 8'h00, 8'h00, CHK_NONE);
        add_entry(K_MEM_RD, 16'h4567, 8'h00, 8'h00, CHK_MODEL);
        add_entry(K_MEM_RD, 16'h3FFF, 8'h00, 8'h00, CHK_MODEL);
        // Section D wraps from page 31 to 0
        add_entry(K_IO_WR, 16'h00FB, 8'h1F, 8'h00, CHK_NONE);
        add_entry(K_MEM_WR, 16'hFFFF, 8'h00, 8'h00, CHK_NONE);
        add_entry(K_MEM_RD, 16'hFFFF, 8'h00, 8'h00, CHK_MODEL);
        add_entry(K_MEM_RD, 16'hC567, 8'h00, 8'h00, CHK_MODEL);
        add_entry(K_MEM_RD, 16'hBFFF, 8'h00, 8'h00, CHK_MODEL);
        // Border, keyboard and an unmapped port
        add_entry(K_IO_WR, 16'h00FE, 8'h1D, 8'h00, CHK_NONE);
        add_entry(K_IO_RD, 16'h7FFE, 8'h00, 8'hAA, CHK_LIT);
        add_entry(K_IO_RD, 16'h00FD, 8'h00, 8'hFF, CHK_LIT);
    endtask

    // ----------------------------------------------------------------------
    // Timeout and video side
    // ----------------------------------------------------------------------
    always @(posedge clk24) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    // New random fetch address every cycle
    always @(posedge clk24) begin
        #1 vid_addr = sam_pkg::ram_addr_t'($random(seed));
    end

    // Ack reports the fetch of the previous cycle
    always @(negedge clk24) begin
        if (rst_n) begin
            if (!prev_vid_req) begin
                check_byte("vid_ack", 8'(vid_ack), 8'h00);
            end else if (prev2_vid_req) begin
                // Slot-0 cycles alternate, so acks alternate too
                check_count++;
                assert (vid_ack !== prev_vid_ack) else begin
                    err_count++;
                    $display("vid_ack did not alternate while video kept requesting");
                end
            end
            if (vid_ack && prev_vid_req) begin
                check_byte("vid_data", vid_data, ref_read(int'(prev_vid_addr)));
            end
        end
        prev_vid_addr = vid_addr;
        prev2_vid_req = prev_vid_req;
        prev_vid_req  = vid_req;
        prev_vid_ack  = vid_ack;
    end

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        int             idx;
        int             cnt;
        int             limit;
        bit             is_rom;
        sam_pkg::byte_t ex;
        seed = 37;
        err_count = 0;
        check_count = 0;
        cycle_count = 0;
        mreq_n = 1'b1;
        iorq_n = 1'b1;
        rd_n = 1'b1;
        wr_n = 1'b1;
        cpu_addr = '0;
        cpu_dout = '0;
        kb_cols = 5'h0A;
        ear = 1'b0;
        vid_req = 1'b0;
        vid_addr = '0;
        prev_vid_addr = '0;
        prev_vid_req = 1'b0;
        prev2_vid_req = 1'b0;
        prev_vid_ack = 1'b0;
        ref_lmpr = '0;
        ref_hmpr = '0;
        build_table();
        cycle_limit = n_entries * 6 + RESET_CYCLES + 200;

        wait (rst_n === 1'b1);
        @(negedge clk24);
        check_byte("wait_n", 8'(wait_n), 8'h01);
        check_byte("sram_we_n", 8'(sram_we_n), 8'h01);
        check_byte("vid_ack", 8'(vid_ack), 8'h00);
        check_byte("border", 8'(border), 8'h00);
        check_byte("mic", 8'(mic), 8'h00);
        check_byte("beep", 8'(beep), 8'h00);

        // Video contends for every slot from here on
        @(posedge clk24);
        #1 vid_req = 1'b1;

        for (int i = 0; i < n_entries; i++) begin
            @(posedge clk24);
            #1;
            cpu_addr = tbl_addr[i];
            cpu_dout = tbl_wdata[i];
            if (tbl_kind[i] == K_MEM_WR) begin
                cpu_dout = sam_pkg::byte_t'($random(seed));
            end
            mreq_n = !(tbl_kind[i] == K_MEM_RD || tbl_kind[i] == K_MEM_WR);
            iorq_n = mreq_n ? 1'b0 : 1'b1;
            wr_n = !(tbl_kind[i] == K_MEM_WR || tbl_kind[i] == K_IO_WR);
            rd_n = !wr_n;
            is_rom = map_is_rom(tbl_addr[i], idx);
            limit = (!mreq_n && !is_rom) ? 3 : 2;

            cnt = 0;
            do begin
                @(negedge clk24);
                cnt++;
            end while (!wait_n);
            check_count++;
            assert (cnt <= limit) else begin
                err_count++;
                $display("Access %0d at 0x%04h took %0d strobe cycles, allowed %0d",
                         i, tbl_addr[i], cnt, limit);
            end
            check_byte("kb_rows", kb_rows, tbl_addr[i][15:8]);

            ex = (tbl_chk[i] == CHK_MODEL) ? ref_read(idx) : tbl_exp[i];
            if (tbl_chk[i] != CHK_NONE) begin
                check_byte("data_to_cpu", data_to_cpu, ex);
            end
            if (tbl_kind[i] == K_MEM_WR) begin
                ref_mem[idx] = cpu_dout;
            end
            if (tbl_kind[i] == K_IO_WR) begin
                case (tbl_addr[i][7:0])
                    8'hFA: ref_lmpr = cpu_dout;
                    8'hFB: ref_hmpr = cpu_dout;
                    8'hFE: begin
                        @(negedge clk24);
                        check_byte("border", 8'(border), 8'(cpu_dout[2:0]));
                        check_byte("mic", 8'(mic), 8'(cpu_dout[3]));
                        check_byte("beep", 8'(beep), 8'(cpu_dout[4]));
                    end
                    default: ;
                endcase
            end

            @(posedge clk24);
            #1;
            mreq_n = 1'b1;
            iorq_n = 1'b1;
            rd_n = 1'b1;
            wr_n = 1'b1;
        end

        @(posedge clk24);
        #1 vid_req = 1'b0;
        repeat (3) @(posedge clk24);
        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== sam_rom.hex ====
// Address marker, then one byte per line in hex
// ROM0 starts at 0000, ROM1 starts at 4000
@0000
F3
AF
11
FF
FF
C3
CB
11
@4000
2A
5D
5C
22
5F
5C
18
43

// ==== filelist.f ====
sam_pkg.sv
sam_rom.sv
sam_mem_map.sv
sam_io_ports.sv
sam_memory_access.sv
sam_bus_top.sv
tb_clock_gen.sv
sram_model.sv
tb_sam_bus.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_sam_bus
RTL_TOP    := sam_bus_top
FILELIST   := filelist.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_TEXT  := Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST)) sam_rom.hex
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
